// ==== src/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	// processor and memory widths
	localparam int ADDR_WIDTH = 32;
	localparam int WORD_WIDTH = 32;
	localparam int LINE_WIDTH = 256;

	// line geometry
	localparam int LINE_BYTES = 32;
	localparam int OFFSET_BITS = 5;
	localparam int WORD_SEL_BITS = 3;
	localparam int WORD_BYTES = 4;

	// store width as encoded on write_size
	typedef enum logic [1:0]
	{
		SIZE_WORD = 2'd0,
		SIZE_BYTE = 2'd1,
		SIZE_HALF = 2'd2,
		SIZE_TRIPLE = 2'd3
	} store_size_t;

	// miss handling states
	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0,
		ST_WRITEBACK = 2'd1,
		ST_REFILL = 2'd2
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/store_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_aligner (
	input wire [dcache_pkg::ADDR_WIDTH-1:0] address,
	input wire [dcache_pkg::WORD_WIDTH-1:0] write_data,
	input dcache_pkg::store_size_t write_size,
	output logic [dcache_pkg::LINE_BYTES-1:0] byte_en,
	output logic [dcache_pkg::LINE_WIDTH-1:0] store_line
);
	import dcache_pkg::*;

	localparam int BYTE_SEL_BITS = OFFSET_BITS - WORD_SEL_BITS;

	logic [BYTE_SEL_BITS-1:0] offset;
	logic [WORD_SEL_BITS-1:0] word_pos;
	// bit 3 is lane 0 at the top of the word
	logic [WORD_BYTES-1:0] lane_mask;
	logic [WORD_WIDTH-1:0] lane_data;

	assign offset = address[BYTE_SEL_BITS-1:0];
	// word 0 sits in the top bits of the line
	assign word_pos = ~address[OFFSET_BITS-1:BYTE_SEL_BITS];

	always_comb
	begin
		lane_mask = '0;
		lane_data = '0;
		case (write_size)
			SIZE_WORD:
			begin
				lane_mask = 4'b1111;
				lane_data = write_data;
			end
			SIZE_BYTE:
			begin
				lane_mask = 4'b1000 >> offset;
				lane_data = {write_data[7:0], 24'b0} >> (8 * offset);
			end
			SIZE_HALF:
			begin
				case (offset)
					2'd0:
					begin
						lane_mask = 4'b1100;
						lane_data = {write_data[15:0], 16'b0};
					end
					2'd1:
					begin
						lane_mask = 4'b0110;
						lane_data = {8'b0, write_data[15:0], 8'b0};
					end
					default:
					begin
						lane_mask = 4'b0011;
						lane_data = {16'b0, write_data[15:0]};
					end
				endcase
			end
			SIZE_TRIPLE:
			begin
				// offsets 2 and 3 leave the line untouched
				if (offset == 2'd0)
				begin
					lane_mask = 4'b1110;
					lane_data = {write_data[23:0], 8'b0};
				end
				else if (offset == 2'd1)
				begin
					lane_mask = 4'b0111;
					lane_data = {8'b0, write_data[23:0]};
				end
			end
		endcase
	end

	always_comb
	begin
		byte_en = '0;
		byte_en[word_pos * WORD_BYTES +: WORD_BYTES] = lane_mask;
	end

	// byte_en picks the lanes out of the repeated word
	assign store_line = {(LINE_WIDTH / WORD_WIDTH){lane_data}};

endmodule

`default_nettype wire

// ==== src/cache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
	parameter int SET_BITS = 9
)(
	input wire CLK,
	input wire RESET,
	input wire [dcache_pkg::ADDR_WIDTH-1:0] address,
	input wire store_req,
	input wire [dcache_pkg::LINE_BYTES-1:0] byte_en,
	input wire [dcache_pkg::LINE_WIDTH-1:0] store_line,
	input wire refill_en,
	input wire [dcache_pkg::LINE_WIDTH-1:0] refill_line,
	output logic hit,
	output logic dirty,
	output logic [dcache_pkg::ADDR_WIDTH-SET_BITS-dcache_pkg::OFFSET_BITS-1:0] tag_out,
	output logic [dcache_pkg::LINE_WIDTH-1:0] line_out
);
	import dcache_pkg::*;

	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;
	localparam int SETS = 1 << SET_BITS;

	logic [SETS-1:0] valid_bits;
	logic [SETS-1:0] dirty_bits;
	logic [TAG_BITS-1:0] tag_mem [SETS];
	logic [LINE_WIDTH-1:0] data_mem [SETS];

	logic [SET_BITS-1:0] set_idx;
	logic [TAG_BITS-1:0] req_tag;
	logic store_hit;

	assign set_idx = address[OFFSET_BITS +: SET_BITS];
	assign req_tag = address[ADDR_WIDTH-1 -: TAG_BITS];

	assign hit = valid_bits[set_idx] && (tag_mem[set_idx] == req_tag);
	assign store_hit = store_req && hit;

	// victim view of this set
	assign dirty = dirty_bits[set_idx];
	assign tag_out = tag_mem[set_idx];
	assign line_out = data_mem[set_idx];

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (refill_en)
		begin
			valid_bits[set_idx] <= 1'b1;
			dirty_bits[set_idx] <= 1'b0;
		end
		else if (store_hit)
		begin
			dirty_bits[set_idx] <= 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (refill_en)
		begin
			tag_mem[set_idx] <= req_tag;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (refill_en)
		begin
			data_mem[set_idx] <= refill_line;
		end
		else if (store_hit)
		begin
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (byte_en[b])
				begin
					data_mem[set_idx][b*8 +: 8] <= store_line[b*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/way_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module way_select #(
	parameter int SET_BITS = 9
)(
	input wire CLK,
	input wire RESET,
	input wire [dcache_pkg::ADDR_WIDTH-1:0] address,
	input wire req,
	input wire [1:0] hit,
	input wire [1:0] dirty,
	input wire [dcache_pkg::ADDR_WIDTH-SET_BITS-dcache_pkg::OFFSET_BITS-1:0] tag_in [2],
	input wire [dcache_pkg::LINE_WIDTH-1:0] line_in [2],
	output logic any_hit,
	output logic [dcache_pkg::WORD_WIDTH-1:0] data_read,
	output logic victim_way,
	output logic victim_dirty,
	output logic [dcache_pkg::ADDR_WIDTH-SET_BITS-dcache_pkg::OFFSET_BITS-1:0] victim_tag,
	output logic [dcache_pkg::LINE_WIDTH-1:0] victim_line
);
	import dcache_pkg::*;

	localparam int BYTE_SEL_BITS = OFFSET_BITS - WORD_SEL_BITS;
	localparam int SETS = 1 << SET_BITS;

	// one bit per set naming the next way to replace
	logic [SETS-1:0] lru_bits;

	logic [SET_BITS-1:0] set_idx;
	logic [WORD_SEL_BITS-1:0] word_pos;
	logic hit_way;
	logic [LINE_WIDTH-1:0] hit_line;

	assign set_idx = address[OFFSET_BITS +: SET_BITS];
	assign word_pos = ~address[OFFSET_BITS-1:BYTE_SEL_BITS];

	assign any_hit = |hit;
	assign hit_way = hit[1];
	assign hit_line = hit_way ? line_in[1] : line_in[0];
	assign data_read = hit_line[word_pos * WORD_WIDTH +: WORD_WIDTH];

	assign victim_way = lru_bits[set_idx];
	assign victim_dirty = dirty[victim_way];
	assign victim_tag = tag_in[victim_way];
	assign victim_line = line_in[victim_way];

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			lru_bits <= '0;
		end
		else if (req && any_hit)
		begin
			// point at the way not just used
			lru_bits[set_idx] <= ~hit_way;
		end
	end

endmodule

`default_nettype wire

// ==== src/miss_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_controller #(
	parameter int SET_BITS = 9
)(
	input wire CLK,
	input wire RESET,
	input wire req,
	input wire any_hit,
	input wire victim_way,
	input wire victim_dirty,
	input wire [dcache_pkg::ADDR_WIDTH-SET_BITS-dcache_pkg::OFFSET_BITS-1:0] victim_tag,
	input wire [dcache_pkg::LINE_WIDTH-1:0] victim_line,
	input wire [dcache_pkg::ADDR_WIDTH-1:0] address,
	input wire mem_write_valid,
	input wire mem_read_valid,
	output logic miss,
	output logic mem_write_req,
	output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_write_addr,
	output logic [dcache_pkg::LINE_WIDTH-1:0] mem_write_data,
	output logic mem_read_req,
	output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_read_addr,
	output logic refill_en,
	output logic refill_way
);
	import dcache_pkg::*;

	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;

	ctrl_state_t state;
	ctrl_state_t state_next;

	logic start_miss;
	logic [ADDR_WIDTH-1:0] saved_addr;
	logic saved_way;
	logic [TAG_BITS-1:0] saved_tag;
	logic [LINE_WIDTH-1:0] saved_line;

	assign miss = req && !any_hit;
	assign start_miss = (state == ST_IDLE) && miss;

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
			begin
				if (miss)
				begin
					state_next = victim_dirty ? ST_WRITEBACK : ST_REFILL;
				end
			end
			ST_WRITEBACK:
			begin
				if (mem_write_valid)
				begin
					state_next = ST_REFILL;
				end
			end
			ST_REFILL:
			begin
				if (mem_read_valid)
				begin
					state_next = ST_IDLE;
				end
			end
			default:
			begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= ST_IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	// snapshot of the miss and its victim
	always_ff @(posedge CLK)
	begin
		if (start_miss)
		begin
			saved_addr <= address;
			saved_way <= victim_way;
			saved_tag <= victim_tag;
			saved_line <= victim_line;
		end
	end

	assign mem_write_req = (state == ST_WRITEBACK);
	assign mem_write_addr = {saved_tag, saved_addr[OFFSET_BITS +: SET_BITS], {OFFSET_BITS{1'b0}}};
	assign mem_write_data = saved_line;

	assign mem_read_req = (state == ST_REFILL);
	assign mem_read_addr = {saved_addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	// line lands on the same edge that samples the read pulse
	assign refill_en = (state == ST_REFILL) && mem_read_valid;
	assign refill_way = saved_way;

endmodule

`default_nettype wire

// ==== src/dcache_l1.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_l1 #(
	parameter int SET_BITS = 9
)(
	input wire CLK,
	input wire RESET,
	input wire cache_read,
	input wire cache_write,
	input wire [dcache_pkg::ADDR_WIDTH-1:0] address,
	input wire [dcache_pkg::WORD_WIDTH-1:0] write_data,
	input dcache_pkg::store_size_t write_size,
	output logic [dcache_pkg::WORD_WIDTH-1:0] data_read,
	output logic miss,
	output logic mem_write_req,
	output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_write_addr,
	output logic [dcache_pkg::LINE_WIDTH-1:0] mem_write_data,
	input wire mem_write_valid,
	output logic mem_read_req,
	output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_read_addr,
	input wire [dcache_pkg::LINE_WIDTH-1:0] mem_read_data,
	input wire mem_read_valid
);
	import dcache_pkg::*;

	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;

	logic req;
	logic store_req;
	logic [LINE_BYTES-1:0] byte_en;
	logic [LINE_WIDTH-1:0] store_line;
	logic [1:0] way_hit;
	logic [1:0] way_dirty;
	logic [TAG_BITS-1:0] way_tag [2];
	logic [LINE_WIDTH-1:0] way_line [2];
	logic any_hit;
	logic victim_way;
	logic victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;
	logic [LINE_WIDTH-1:0] victim_line;
	logic refill_en;
	logic refill_way;

	assign req = cache_read | cache_write;
	// stores only commit in the way that hits
	assign store_req = cache_write;

	store_aligner u_aligner (
		.address(address),
		.write_data(write_data),
		.write_size(write_size),
		.byte_en(byte_en),
		.store_line(store_line)
	);

	for (genvar g = 0; g < 2; g++)
	begin : g_way
		cache_way #(.SET_BITS(SET_BITS)) u_way (
			.CLK(CLK),
			.RESET(RESET),
			.address(address),
			.store_req(store_req),
			.byte_en(byte_en),
			.store_line(store_line),
			.refill_en(refill_en && (refill_way == 1'(g))),
			.refill_line(mem_read_data),
			.hit(way_hit[g]),
			.dirty(way_dirty[g]),
			.tag_out(way_tag[g]),
			.line_out(way_line[g])
		);
	end

	way_select #(.SET_BITS(SET_BITS)) u_select (
		.CLK(CLK),
		.RESET(RESET),
		.address(address),
		.req(req),
		.hit(way_hit),
		.dirty(way_dirty),
		.tag_in(way_tag),
		.line_in(way_line),
		.any_hit(any_hit),
		.data_read(data_read),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_line(victim_line)
	);

	miss_controller #(.SET_BITS(SET_BITS)) u_ctrl (
		.CLK(CLK),
		.RESET(RESET),
		.req(req),
		.any_hit(any_hit),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_line(victim_line),
		.address(address),
		.mem_write_valid(mem_write_valid),
		.mem_read_valid(mem_read_valid),
		.miss(miss),
		.mem_write_req(mem_write_req),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_read_req(mem_read_req),
		.mem_read_addr(mem_read_addr),
		.refill_en(refill_en),
		.refill_way(refill_way)
	);

endmodule

`default_nettype wire

// ==== test/tb_dcache_l1.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_l1;
	import dcache_pkg::*;

	localparam int SET_BITS = 2;
	localparam int SETS = 1 << SET_BITS;
	localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_BITS;
	localparam int RANDOM_OPS = 300;
	localparam int OP_COUNT = 2 + 32 + 3 + 6 + RANDOM_OPS;
	// drive, write-back and refill at the longest responder delay
	localparam int MISS_CYCLES = 16;
	localparam int CYCLE_LIMIT = 20 + OP_COUNT * MISS_CYCLES;

	logic CLK;
	logic RESET;
	logic cache_read;
	logic cache_write;
	logic [ADDR_WIDTH-1:0] address;
	logic [WORD_WIDTH-1:0] write_data;
	store_size_t write_size;
	logic [WORD_WIDTH-1:0] data_read;
	logic miss;
	logic mem_write_req;
	logic [ADDR_WIDTH-1:0] mem_write_addr;
	logic [LINE_WIDTH-1:0] mem_write_data;
	logic mem_write_valid = 1'b0;
	logic mem_read_req;
	logic [ADDR_WIDTH-1:0] mem_read_addr;
	logic [LINE_WIDTH-1:0] mem_read_data = '0;
	logic mem_read_valid = 1'b0;

	// backing store keyed by line address
	logic [LINE_WIDTH-1:0] backing [logic [ADDR_WIDTH-1:0]];

	// reference cache
	logic m_valid [SETS][2];
	logic m_dirty [SETS][2];
	logic [TAG_BITS-1:0] m_tag [SETS][2];
	logic [LINE_WIDTH-1:0] m_line [SETS][2];
	logic m_lru [SETS];

	logic [ADDR_WIDTH-1:0] exp_wb_addr;
	logic [LINE_WIDTH-1:0] exp_wb_data;
	logic [ADDR_WIDTH-1:0] exp_rd_addr;
	int wb_count = 0;
	int rd_count = 0;
	int wr_wait = 0;
	int rd_wait = 0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	logic [31:0] stim_lfsr = 32'h4097;
	logic [31:0] delay_lfsr = 32'h4097;

	dcache_l1 #(.SET_BITS(SET_BITS)) UUT (
		.CLK(CLK),
		.RESET(RESET),
		.cache_read(cache_read),
		.cache_write(cache_write),
		.address(address),
		.write_data(write_data),
		.write_size(write_size),
		.data_read(data_read),
		.miss(miss),
		.mem_write_req(mem_write_req),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_write_valid(mem_write_valid),
		.mem_read_req(mem_read_req),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.mem_read_valid(mem_read_valid)
	);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
	endtask

	// 1 to 4 cycles
	function automatic int next_delay();
		int d;
		d = 1;
		for (int i = 0; i < 2; i++)
		begin
			delay_lfsr = lfsr_next(delay_lfsr);
			d = d + (int'(delay_lfsr[0]) << i);
		end
		return d;
	endfunction

	function automatic logic [LINE_WIDTH-1:0] line_at(input logic [ADDR_WIDTH-1:0] a);
		logic [LINE_WIDTH-1:0] l;
		if (backing.exists(a))
		begin
			return backing[a];
		end
		for (int w = 0; w < 8; w++)
		begin
			l[255 - 32*w -: 32] = ((a + 32'(w * 4)) * 32'h9e3779b1) ^ 32'h5a3c96e1;
		end
		return l;
	endfunction

	function automatic logic [WORD_WIDTH-1:0] word_at(input logic [LINE_WIDTH-1:0] l,
		input logic [4:0] offset);
		return l[255 - 32*int'(offset[4:2]) -: 32];
	endfunction

	// big-endian lanes with data from the low bits of the word
	function automatic logic [LINE_WIDTH-1:0] merge_store(input logic [LINE_WIDTH-1:0] l,
		input logic [4:0] offset, input logic [31:0] data, input logic [1:0] size);
		int lane;
		int start;
		int n;
		lane = int'(offset[1:0]);
		start = 0;
		n = 0;
		case (size)
			2'd0:
			begin
				n = 4;
			end
			2'd1:
			begin
				start = lane;
				n = 1;
			end
			2'd2:
			begin
				start = (lane == 3) ? 2 : lane;
				n = 2;
			end
			default:
			begin
				start = lane;
				n = (lane < 2) ? 3 : 0;
			end
		endcase
		for (int i = 0; i < n; i++)
		begin
			l[255 - 8*(int'(offset[4:2])*4 + start + i) -: 8] = data[8*(n-1-i) +: 8];
		end
		return l;
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] make_addr(input int tag_idx, input int set_i,
		input logic [4:0] offset);
		logic [TAG_BITS-1:0] tag;
		tag = TAG_BITS'(32'h0001a2b + tag_idx * 32'h0030571);
		return {tag, SET_BITS'(set_i), offset};
	endfunction

	task automatic access(input logic write, input logic [ADDR_WIDTH-1:0] addr,
		input logic [31:0] data, input logic [1:0] size,
		output logic saw_miss, output logic saw_mem);
		int set_i;
		int way;
		int exp_wbs;
		int exp_rds;
		int wb_before;
		int rd_before;
		logic [TAG_BITS-1:0] tag;
		logic [WORD_WIDTH-1:0] expect_word;
		set_i = int'(addr[OFFSET_BITS +: SET_BITS]);
		tag = addr[ADDR_WIDTH-1 -: TAG_BITS];
		way = -1;
		exp_wbs = 0;
		exp_rds = 0;
		wb_before = wb_count;
		rd_before = rd_count;
		for (int w = 0; w < 2; w++)
		begin
			if (m_valid[set_i][w] && m_tag[set_i][w] == tag)
			begin
				way = w;
			end
		end
		if (way < 0)
		begin
			way = m_lru[set_i] ? 1 : 0;
			if (m_dirty[set_i][way])
			begin
				exp_wb_addr = {m_tag[set_i][way], SET_BITS'(set_i), 5'b0};
				exp_wb_data = m_line[set_i][way];
				backing[exp_wb_addr] = exp_wb_data;
				exp_wbs = 1;
			end
			exp_rd_addr = {addr[ADDR_WIDTH-1:OFFSET_BITS], 5'b0};
			m_line[set_i][way] = line_at(exp_rd_addr);
			m_tag[set_i][way] = tag;
			m_valid[set_i][way] = 1'b1;
			m_dirty[set_i][way] = 1'b0;
			exp_rds = 1;
		end
		m_lru[set_i] = (way == 0);
		if (write)
		begin
			m_line[set_i][way] = merge_store(m_line[set_i][way], addr[4:0], data, size);
			m_dirty[set_i][way] = 1'b1;
		end
		expect_word = word_at(m_line[set_i][way], addr[4:0]);

		@(posedge CLK);
		address <= addr;
		write_data <= data;
		write_size <= store_size_t'(size);
		cache_read <= !write;
		cache_write <= write;
		saw_miss = 1'b0;
		@(negedge CLK);
		while (miss)
		begin
			saw_miss = 1'b1;
			@(negedge CLK);
		end
		checks++;
		if (!write && data_read !== expect_word)
		begin
			errors++;
			$display("Mismatch at %0t: read of 0x%08h gave 0x%08h, expected 0x%08h",
				$time, addr, data_read, expect_word);
		end
		if (saw_miss !== (exp_rds == 1))
		begin
			errors++;
			$display("Mismatch at %0t: miss was %0b for 0x%08h, expected %0b",
				$time, saw_miss, addr, exp_rds);
		end
		if (wb_count - wb_before != exp_wbs || rd_count - rd_before != exp_rds)
		begin
			errors++;
			$display("Mismatch at %0t: 0x%08h made %0d write-backs and %0d refills",
				$time, addr, wb_count - wb_before, rd_count - rd_before);
		end
		saw_mem = (wb_count != wb_before) || (rd_count != rd_before);
		@(posedge CLK);
		cache_read <= 1'b0;
		cache_write <= 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %s finished, %0d errors", name, errors - errors_before);
	endtask

	// memory answers each request level after a short random wait
	always @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			mem_write_valid <= 1'b0;
			mem_read_valid <= 1'b0;
			wr_wait = 0;
			rd_wait = 0;
		end
		else
		begin
			mem_write_valid <= 1'b0;
			mem_read_valid <= 1'b0;
			if (mem_write_req && !mem_write_valid)
			begin
				if (wr_wait == 0)
				begin
					wr_wait = next_delay();
				end
				else
				begin
					wr_wait = wr_wait - 1;
					if (wr_wait == 0)
					begin
						mem_write_valid <= 1'b1;
						wb_count++;
						checks++;
						if (mem_write_addr !== exp_wb_addr || mem_write_data !== exp_wb_data)
						begin
							errors++;
							$display("Mismatch at %0t: write-back to 0x%08h, expected 0x%08h",
								$time, mem_write_addr, exp_wb_addr);
						end
					end
				end
			end
			if (mem_read_req && !mem_read_valid)
			begin
				if (rd_wait == 0)
				begin
					rd_wait = next_delay();
				end
				else
				begin
					rd_wait = rd_wait - 1;
					if (rd_wait == 0)
					begin
						mem_read_valid <= 1'b1;
						mem_read_data <= line_at(mem_read_addr);
						rd_count++;
						checks++;
						if (mem_read_addr !== exp_rd_addr)
						begin
							errors++;
							$display("Mismatch at %0t: refill from 0x%08h, expected 0x%08h",
								$time, mem_read_addr, exp_rd_addr);
						end
					end
				end
			end
		end
	end

	always @(posedge CLK)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, an access never completed", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	initial
	begin
		logic saw_miss;
		logic saw_mem;
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] o;
		logic [31:0] s;
		logic [31:0] z;
		int err0;
		int wb0;

		RESET = 1'b0;
		cache_read = 1'b0;
		cache_write = 1'b0;
		address = '0;
		write_data = '0;
		write_size = SIZE_WORD;
		for (int i = 0; i < SETS; i++)
		begin
			m_lru[i] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				m_valid[i][w] = 1'b0;
				m_dirty[i][w] = 1'b0;
			end
		end
		repeat (3) @(posedge CLK);
		RESET <= 1'b1;

		err0 = errors;
		@(negedge CLK);
		checks++;
		if (mem_write_req !== 1'b0 || mem_read_req !== 1'b0)
		begin
			errors++;
			$display("a memory request was raised right after reset");
		end
		access(1'b0, make_addr(0, 0, 5'd4), 32'h0, 2'd0, saw_miss, saw_mem);
		if (!saw_miss)
		begin
			errors++;
			$display("the first read after reset did not miss");
		end
		report_test("reset", err0);

		err0 = errors;
		access(1'b0, make_addr(1, 0, 5'd22), 32'h0, 2'd0, saw_miss, saw_mem);
		report_test("read_refill", err0);

		err0 = errors;
		for (int sz = 0; sz < 4; sz++)
		begin
			for (int off = 0; off < 4; off++)
			begin
				take_bits(3, o);
				take_bits(32, d);
				access(1'b1, make_addr(0, 1, {o[2:0], 2'(off)}), d, 2'(sz), saw_miss, saw_mem);
				access(1'b0, make_addr(0, 1, {o[2:0], 2'b00}), 32'h0, 2'd0, saw_miss, saw_mem);
			end
		end
		report_test("sub_word_stores", err0);

		err0 = errors;
		access(1'b1, make_addr(0, 2, 5'd8), 32'hcafe1234, 2'd0, saw_miss, saw_mem);
		access(1'b0, make_addr(1, 2, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		wb0 = wb_count;
		access(1'b0, make_addr(2, 2, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		if (wb_count == wb0)
		begin
			errors++;
			$display("evicting a dirty line produced no write-back");
		end
		report_test("dirty_eviction", err0);

		err0 = errors;
		access(1'b0, make_addr(0, 3, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		access(1'b0, make_addr(1, 3, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		access(1'b0, make_addr(0, 3, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		access(1'b0, make_addr(2, 3, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		access(1'b0, make_addr(0, 3, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		if (saw_miss || saw_mem)
		begin
			errors++;
			$display("the recently used line was evicted instead of the older one");
		end
		access(1'b0, make_addr(1, 3, 5'd0), 32'h0, 2'd0, saw_miss, saw_mem);
		if (!saw_miss)
		begin
			errors++;
			$display("the older line was still present after a conflict");
		end
		report_test("recency", err0);

		err0 = errors;
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			take_bits(2, r);
			take_bits(2, s);
			take_bits(2, z);
			take_bits(5, o);
			take_bits(32, d);
			access(1'(r[0]), make_addr(int'(o[1:0]) % 3, int'(s[1:0]), o[4:0] ^ 5'(i)),
				d, r[1] ? 2'(z) : 2'd0, saw_miss, saw_mem);
		end
		report_test("random_mix", err0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dcache_l1.f ====
src/dcache_pkg.sv
src/store_aligner.sv
src/cache_way.sv
src/way_select.sv
src/miss_controller.sv
src/dcache_l1.sv
test/tb_dcache_l1.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log
verilator --binary --timing -f dcache_l1.f --top-module tb_dcache_l1 -o tb_dcache_l1 \
	|| exit 1
./obj_dir/tb_dcache_l1 > sim.log 2>&1 && cat sim.log || cat sim.log
grep -qxF '** PASS **' sim.log && echo "simulation passed" || exit 1
